//--- hdl/valu_defines.svh
// vector ALU width macros
// datapath word, lane count and the per-element mask width
// ----------------------------------------

`ifndef VALU_DEFINES_SVH
`define VALU_DEFINES_SVH

// ----------------------------------------
// datapath
// ----------------------------------------

`define VALU_XLEN 64                  // one vector register slice

// ----------------------------------------
// lanes and masks
// ----------------------------------------

// one enable bit per 8-bit lane, also the compare mask width
`define VALU_BYTES (`VALU_XLEN/8)

`endif

//--- hdl/valu_pkg.sv
// vector ALU package
// element width, opcode and lane view types shared by the datapath

`include "valu_defines.svh"

package valu_pkg;

    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2,
        EW64 = 2'd3
    } valu_ew_t;

    // codes above MSGT are illegal
    typedef enum logic [4:0] {
        MV    = 5'd0,
        ADD   = 5'd1,  SUB   = 5'd2,  RSUB  = 5'd3,
        MAXU  = 5'd4,  MAX   = 5'd5,  MINU  = 5'd6,  MIN  = 5'd7,
        SLL   = 5'd8,  SRL   = 5'd9,  SRA   = 5'd10,
        AND   = 5'd11, OR    = 5'd12, XOR   = 5'd13, ANDN = 5'd14,
        ORN   = 5'd15, NAND  = 5'd16, NOR   = 5'd17, XNOR = 5'd18,
        MSEQ  = 5'd19, MSNE  = 5'd20, MSLTU = 5'd21, MSLT = 5'd22,
        MSLEU = 5'd23, MSLE  = 5'd24, MSGTU = 5'd25, MSGT = 5'd26
    } valu_op_t;

    // element 0 is the least significant
    typedef union packed {
        logic [`VALU_XLEN/64-1:0][63:0] w64;
        logic [`VALU_XLEN/32-1:0][31:0] w32;
        logic [`VALU_XLEN/16-1:0][15:0] w16;
        logic [`VALU_BYTES-1:0][7:0]    w8;
    } valu_lanes_t;

    // sign extend the low SEW bits to the full word
    function automatic logic [`VALU_XLEN-1:0] valu_sext(input valu_ew_t sew,
                                                        input logic [`VALU_XLEN-1:0] x);
        logic [`VALU_XLEN-1:0] r;
        case (sew)
            EW8:     r = {{(`VALU_XLEN-8){x[7]}}, x[7:0]};
            EW16:    r = {{(`VALU_XLEN-16){x[15]}}, x[15:0]};
            EW32:    r = {{(`VALU_XLEN-32){x[31]}}, x[31:0]};
            default: r = x;
        endcase
        return r;
    endfunction

endpackage

//--- hdl/valu_operand_stage.sv
// vector ALU operand stage
// broadcasts the scalar operand per SEW, selects it against vs1
// and registers the full operand set on issue

`timescale 1ns/1ps
`include "valu_defines.svh"

module valu_operand_stage (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_valid,
    input  valu_pkg::valu_op_t       i_op,
    input  valu_pkg::valu_ew_t       i_sew,
    input  logic [`VALU_XLEN-1:0]    i_vs1,
    input  logic                     i_rs1_valid,
    input  logic [`VALU_XLEN-1:0]    i_rs1,
    input  logic [`VALU_XLEN-1:0]    i_vs2,
    input  logic [`VALU_XLEN-1:0]    i_wr_old,
    input  logic [`VALU_BYTES-1:0]   i_wr_mask_old,
    input  logic [`VALU_BYTES-1:0]   i_en_mask,
    output logic                     o_valid,
    output valu_pkg::valu_op_t       o_op,
    output valu_pkg::valu_ew_t       o_sew,
    output valu_pkg::valu_lanes_t    o_opa,
    output valu_pkg::valu_lanes_t    o_vs2,
    output valu_pkg::valu_lanes_t    o_old,
    output logic [`VALU_BYTES-1:0]   o_mask_old,
    output logic [`VALU_BYTES-1:0]   o_en
);
    import valu_pkg::*;

    valu_lanes_t w_bcast;
    valu_lanes_t w_opa;

    // ----------------------------------------
    // scalar broadcast
    // ----------------------------------------
    always_comb begin
        w_bcast = '0;
        case (i_sew)
            EW8: begin
                for (int e = 0; e < `VALU_BYTES; e++) begin
                    w_bcast.w8[e] = i_rs1[7:0];
                end
            end
            EW16: begin
                for (int e = 0; e < `VALU_XLEN/16; e++) begin
                    w_bcast.w16[e] = i_rs1[15:0];
                end
            end
            EW32: begin
                for (int e = 0; e < `VALU_XLEN/32; e++) begin
                    w_bcast.w32[e] = i_rs1[31:0];
                end
            end
            default: w_bcast.w64[0] = i_rs1;
        endcase
    end

    assign w_opa = i_rs1_valid ? w_bcast : valu_lanes_t'(i_vs1);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin        // payload only moves on issue
            o_op       <= i_op;
            o_sew      <= i_sew;
            o_opa      <= w_opa;
            o_vs2      <= i_vs2;
            o_old      <= i_wr_old;
            o_mask_old <= i_wr_mask_old;
            o_en       <= i_en_mask;
        end
    end

    a_legal_op: assert property (@(posedge i_clk) disable iff (i_rst)
        i_valid |-> (i_op <= MSGT));

endmodule

//--- hdl/valu_arith_unit.sv
// vector ALU arithmetic unit
// per-element move, add/sub, min/max and shifts at the current SEW,
// full-word bitwise ops, zero for compares and illegal codes

`timescale 1ns/1ps
`include "valu_defines.svh"

module valu_arith_unit (
    input  valu_pkg::valu_op_t    i_op,
    input  valu_pkg::valu_ew_t    i_sew,
    input  valu_pkg::valu_lanes_t i_opa,
    input  valu_pkg::valu_lanes_t i_vs2,
    output valu_pkg::valu_lanes_t o_res
);
    import valu_pkg::*;

    valu_lanes_t w_res;

    // ----------------------------------------
    // one element, operands zero padded
    // ----------------------------------------
    function automatic logic [`VALU_XLEN-1:0] elem_calc(input valu_op_t op,
                                                        input valu_ew_t sew,
                                                        input logic [`VALU_XLEN-1:0] a,
                                                        input logic [`VALU_XLEN-1:0] b);
        logic [`VALU_XLEN-1:0] as;
        logic [`VALU_XLEN-1:0] bs;
        logic [5:0]            sh;
        logic [`VALU_XLEN-1:0] res;
        as = valu_sext(sew, a);
        bs = valu_sext(sew, b);
        sh = a[5:0] & 6'((8 << sew) - 1);     // log2(SEW) bits
        case (op)
            MV:      res = a;
            ADD:     res = b + a;
            SUB:     res = b - a;
            RSUB:    res = a - b;
            MAXU:    res = (b > a) ? b : a;
            MAX:     res = ($signed(bs) > $signed(as)) ? b : a;
            MINU:    res = (b < a) ? b : a;
            MIN:     res = ($signed(bs) < $signed(as)) ? b : a;
            SLL:     res = b << sh;
            SRL:     res = b >> sh;
            SRA:     res = $signed(bs) >>> sh;
            default: res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        w_res = '0;
        case (i_op)
            MV, ADD, SUB, RSUB, MAXU, MAX, MINU, MIN, SLL, SRL, SRA: begin
                case (i_sew)
                    EW8: begin
                        for (int e = 0; e < `VALU_BYTES; e++) begin
                            w_res.w8[e] = 8'(elem_calc(i_op, i_sew,
                                                       `VALU_XLEN'(i_opa.w8[e]),
                                                       `VALU_XLEN'(i_vs2.w8[e])));
                        end
                    end
                    EW16: begin
                        for (int e = 0; e < `VALU_XLEN/16; e++) begin
                            w_res.w16[e] = 16'(elem_calc(i_op, i_sew,
                                                         `VALU_XLEN'(i_opa.w16[e]),
                                                         `VALU_XLEN'(i_vs2.w16[e])));
                        end
                    end
                    EW32: begin
                        for (int e = 0; e < `VALU_XLEN/32; e++) begin
                            w_res.w32[e] = 32'(elem_calc(i_op, i_sew,
                                                         `VALU_XLEN'(i_opa.w32[e]),
                                                         `VALU_XLEN'(i_vs2.w32[e])));
                        end
                    end
                    default: begin
                        w_res.w64[0] = elem_calc(i_op, i_sew, i_opa.w64[0], i_vs2.w64[0]);
                    end
                endcase
            end

            // bitwise ops ignore SEW
            AND:  w_res =   i_vs2 &  i_opa;
            OR:   w_res =   i_vs2 |  i_opa;
            XOR:  w_res =   i_vs2 ^  i_opa;
            ANDN: w_res =   i_vs2 & ~i_opa;
            ORN:  w_res =   i_vs2 | ~i_opa;
            NAND: w_res = ~(i_vs2 &  i_opa);
            NOR:  w_res = ~(i_vs2 |  i_opa);
            XNOR: w_res = ~(i_vs2 ^  i_opa);

            default: w_res = '0;          // compares and illegal codes
        endcase
    end

    assign o_res = w_res;

endmodule

//--- hdl/valu_compare_unit.sv
// vector ALU compare unit
// integer compares of vs2 against operand A, one mask bit
// per element packed from bit 0

`timescale 1ns/1ps
`include "valu_defines.svh"

module valu_compare_unit (
    input  valu_pkg::valu_op_t      i_op,
    input  valu_pkg::valu_ew_t      i_sew,
    input  valu_pkg::valu_lanes_t   i_opa,
    input  valu_pkg::valu_lanes_t   i_vs2,
    output logic [`VALU_BYTES-1:0]  o_mask
);
    import valu_pkg::*;

    logic [`VALU_BYTES-1:0] w_mask;

    // zero padded element in, single result bit out
    function automatic logic cmp_calc(input valu_op_t op,
                                      input valu_ew_t sew,
                                      input logic [`VALU_XLEN-1:0] a,
                                      input logic [`VALU_XLEN-1:0] b);
        logic signed [`VALU_XLEN-1:0] as;
        logic signed [`VALU_XLEN-1:0] bs;
        logic                         res;
        as = valu_sext(sew, a);
        bs = valu_sext(sew, b);
        case (op)
            MSEQ:    res = (b == a);
            MSNE:    res = (b != a);
            MSLTU:   res = (b <  a);
            MSLT:    res = (bs <  as);
            MSLEU:   res = (b <= a);
            MSLE:    res = (bs <= as);
            MSGTU:   res = (b >  a);
            MSGT:    res = (bs >  as);
            default: res = 1'b0;        // not a compare
        endcase
        return res;
    endfunction

    // ----------------------------------------
    // per-element mask bits
    // ----------------------------------------
    always_comb begin
        w_mask = '0;                    // upper bits stay clear
        case (i_sew)
            EW8: begin
                for (int e = 0; e < `VALU_BYTES; e++) begin
                    w_mask[e] = cmp_calc(i_op, i_sew, `VALU_XLEN'(i_opa.w8[e]),
                                         `VALU_XLEN'(i_vs2.w8[e]));
                end
            end
            EW16: begin
                for (int e = 0; e < `VALU_XLEN/16; e++) begin
                    w_mask[e] = cmp_calc(i_op, i_sew, `VALU_XLEN'(i_opa.w16[e]),
                                         `VALU_XLEN'(i_vs2.w16[e]));
                end
            end
            EW32: begin
                for (int e = 0; e < `VALU_XLEN/32; e++) begin
                    w_mask[e] = cmp_calc(i_op, i_sew, `VALU_XLEN'(i_opa.w32[e]),
                                         `VALU_XLEN'(i_vs2.w32[e]));
                end
            end
            default: begin
                w_mask[0] = cmp_calc(i_op, i_sew, i_opa.w64[0], i_vs2.w64[0]);
            end
        endcase
    end

    assign o_mask = w_mask;

endmodule

//--- hdl/valu_result_merge.sv
// vector ALU result merge stage
// picks new or old per element for the data and mask results
// under the enable mask, then registers both on a valid operation

`timescale 1ns/1ps
`include "valu_defines.svh"

module valu_result_merge (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  valu_pkg::valu_ew_t      i_sew,
    input  valu_pkg::valu_lanes_t   i_arith_res,
    input  valu_pkg::valu_lanes_t   i_old,
    input  logic [`VALU_BYTES-1:0]  i_cmp_mask,
    input  logic [`VALU_BYTES-1:0]  i_mask_old,
    input  logic [`VALU_BYTES-1:0]  i_en,
    output logic                    o_valid,
    output logic [`VALU_XLEN-1:0]   o_alu_res,
    output logic [`VALU_BYTES-1:0]  o_mask_res
);
    import valu_pkg::*;

    valu_lanes_t            w_alu;
    logic [`VALU_BYTES-1:0] w_mask;

    // 8, 4, 2 or 1 elements
    function automatic int elem_cnt(input valu_ew_t sew);
        return `VALU_BYTES >> sew;
    endfunction

    // ----------------------------------------
    // element select
    // ----------------------------------------
    always_comb begin
        w_alu = i_old;
        case (i_sew)
            EW8: begin
                for (int e = 0; e < `VALU_BYTES; e++) begin
                    w_alu.w8[e] = i_en[e] ? i_arith_res.w8[e] : i_old.w8[e];
                end
            end
            EW16: begin
                for (int e = 0; e < `VALU_XLEN/16; e++) begin
                    w_alu.w16[e] = i_en[e] ? i_arith_res.w16[e] : i_old.w16[e];
                end
            end
            EW32: begin
                for (int e = 0; e < `VALU_XLEN/32; e++) begin
                    w_alu.w32[e] = i_en[e] ? i_arith_res.w32[e] : i_old.w32[e];
                end
            end
            default: w_alu.w64[0] = i_en[0] ? i_arith_res.w64[0] : i_old.w64[0];
        endcase

        for (int b = 0; b < `VALU_BYTES; b++) begin
            if (b < elem_cnt(i_sew)) begin
                w_mask[b] = i_en[b] ? i_cmp_mask[b] : i_mask_old[b];
            end else begin
                w_mask[b] = 1'b0;             // past the last element
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin                    // hold while idle
            o_alu_res  <= w_alu;
            o_mask_res <= w_mask;
        end
    end

    a_mask_upper_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        i_valid |=> ((o_mask_res >> elem_cnt($past(i_sew))) == '0));

    a_valid_source: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_valid) |-> $past(i_valid));

endmodule

//--- hdl/valu_top.sv
// vector ALU top level
// two-stage pipeline: operand stage, arithmetic and compare units
// side by side, then the merge stage

`timescale 1ns/1ps
`include "valu_defines.svh"

module valu_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  valu_pkg::valu_op_t      i_op,
    input  valu_pkg::valu_ew_t      i_sew,
    input  logic [`VALU_XLEN-1:0]   i_vs1,
    input  logic                    i_rs1_valid,
    input  logic [`VALU_XLEN-1:0]   i_rs1,
    input  logic [`VALU_XLEN-1:0]   i_vs2,
    input  logic [`VALU_XLEN-1:0]   i_wr_old,
    input  logic [`VALU_BYTES-1:0]  i_wr_mask_old,
    input  logic [`VALU_BYTES-1:0]  i_en_mask,
    output logic                    o_valid,
    output logic [`VALU_XLEN-1:0]   o_alu_res,
    output logic [`VALU_BYTES-1:0]  o_mask_res
);
    import valu_pkg::*;

    // ----------------------------------------
    // stage 1 operand set
    // ----------------------------------------
    logic                   s1_valid;
    valu_op_t               s1_op;
    valu_ew_t               s1_sew;
    valu_lanes_t            s1_opa;
    valu_lanes_t            s1_vs2;
    valu_lanes_t            s1_old;
    logic [`VALU_BYTES-1:0] s1_mask_old;
    logic [`VALU_BYTES-1:0] s1_en;

    valu_lanes_t            arith_res;
    logic [`VALU_BYTES-1:0] cmp_mask;

    valu_operand_stage u_operand_stage (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_op(i_op), .i_sew(i_sew),
        .i_vs1(i_vs1), .i_rs1_valid(i_rs1_valid), .i_rs1(i_rs1), .i_vs2(i_vs2),
        .i_wr_old(i_wr_old), .i_wr_mask_old(i_wr_mask_old), .i_en_mask(i_en_mask),
        .o_valid(s1_valid), .o_op(s1_op), .o_sew(s1_sew), .o_opa(s1_opa),
        .o_vs2(s1_vs2), .o_old(s1_old), .o_mask_old(s1_mask_old), .o_en(s1_en)
    );

    valu_arith_unit u_arith_unit (
        .i_op(s1_op), .i_sew(s1_sew), .i_opa(s1_opa), .i_vs2(s1_vs2), .o_res(arith_res)
    );

    valu_compare_unit u_compare_unit (
        .i_op(s1_op), .i_sew(s1_sew), .i_opa(s1_opa), .i_vs2(s1_vs2), .o_mask(cmp_mask)
    );

    valu_result_merge u_result_merge (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(s1_valid), .i_sew(s1_sew),
        .i_arith_res(arith_res), .i_old(s1_old), .i_cmp_mask(cmp_mask),
        .i_mask_old(s1_mask_old), .i_en(s1_en),
        .o_valid(o_valid), .o_alu_res(o_alu_res), .o_mask_res(o_mask_res)
    );

endmodule

//--- tests/tb_valu_top.sv
// vector ALU testbench
// random operations at every SEW against a reference model kept in a queue,
// results checked for value and for exact 2-cycle latency

`timescale 1ns/1ps
`include "valu_defines.svh"

module tb_valu_top;
    import valu_pkg::*;

    localparam int RST_CYC    = 16;
    localparam int N_ARITH    = 200;
    localparam int N_BITWISE  = 150;
    localparam int N_CMP_REP  = 8;                       // per op and SEW
    localparam int N_ENABLE   = 200;
    localparam int N_B2B      = 400;
    localparam int TOTAL_OPS  = 1 + N_ARITH + N_BITWISE + 8 * 4 * N_CMP_REP + N_ENABLE + N_B2B;
    localparam int DRAIN_CYC  = 64;
    localparam int TIMEOUT_CYC = 2 * TOTAL_OPS + RST_CYC + DRAIN_CYC;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_valid;
    valu_op_t               i_op;
    valu_ew_t               i_sew;
    logic [`VALU_XLEN-1:0]  i_vs1;
    logic                   i_rs1_valid;
    logic [`VALU_XLEN-1:0]  i_rs1;
    logic [`VALU_XLEN-1:0]  i_vs2;
    logic [`VALU_XLEN-1:0]  i_wr_old;
    logic [`VALU_BYTES-1:0] i_wr_mask_old;
    logic [`VALU_BYTES-1:0] i_en_mask;
    logic                   o_valid;
    logic [`VALU_XLEN-1:0]  o_alu_res;
    logic [`VALU_BYTES-1:0] o_mask_res;

    logic [`VALU_XLEN-1:0]  exp_alu[$];
    logic [`VALU_BYTES-1:0] exp_mask[$];
    int                     exp_due[$];                  // cycle the result must show up
    int cyc = 0;
    int errors = 0;
    int n_checks = 0;
    int n_ops = 0;
    int test_err0 = 0;
    int test_ops0 = 0;

    valu_top dut (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_op(i_op), .i_sew(i_sew),
        .i_vs1(i_vs1), .i_rs1_valid(i_rs1_valid), .i_rs1(i_rs1), .i_vs2(i_vs2),
        .i_wr_old(i_wr_old), .i_wr_mask_old(i_wr_mask_old), .i_en_mask(i_en_mask),
        .o_valid(o_valid), .o_alu_res(o_alu_res), .o_mask_res(o_mask_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc == TIMEOUT_CYC) begin
            $display("timeout after %0d cycles with %0d results outstanding", cyc, exp_due.size());
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [63:0] elem_mask(input int w);
        return (w == `VALU_XLEN) ? '1 : ((64'd1 << w) - 64'd1);
    endfunction

    function automatic logic [63:0] alu_elem(input valu_op_t op, input int w,
                                             input logic [63:0] a, input logic [63:0] b);
        logic [63:0] m;
        logic [63:0] sb;
        logic [63:0] bx;
        logic [5:0]  sh;
        logic [63:0] r;
        m  = elem_mask(w);
        sb = 64'd1 << (w - 1);                           // sign bit of the element
        sh = a[5:0] & 6'(w - 1);
        bx = ((b & sb) != 0) ? (b | ~m) : b;
        case (op)
            MV:      r = a;
            ADD:     r = b + a;
            SUB:     r = b - a;
            RSUB:    r = a - b;
            MAXU:    r = (b > a) ? b : a;
            MAX:     r = ((b ^ sb) > (a ^ sb)) ? b : a;  // flipped sign bit orders signed values
            MINU:    r = (b < a) ? b : a;
            MIN:     r = ((b ^ sb) < (a ^ sb)) ? b : a;
            SLL:     r = b << sh;
            SRL:     r = b >> sh;
            SRA:     r = $signed(bx) >>> sh;
            default: r = '0;
        endcase
        return r & m;
    endfunction

    function automatic logic cmp_elem(input valu_op_t op, input int w,
                                      input logic [63:0] a, input logic [63:0] b);
        logic [63:0] sb;
        sb = 64'd1 << (w - 1);
        case (op)
            MSEQ:    return b == a;
            MSNE:    return b != a;
            MSLTU:   return b < a;
            MSLT:    return (b ^ sb) < (a ^ sb);
            MSLEU:   return b <= a;
            MSLE:    return (b ^ sb) <= (a ^ sb);
            MSGTU:   return b > a;
            MSGT:    return (b ^ sb) > (a ^ sb);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] operand_a(input valu_ew_t sew, input logic rs1v,
                                              input logic [63:0] vs1, input logic [63:0] rs1);
        int          w;
        logic [63:0] r;
        w = 8 << sew;
        r = '0;
        for (int i = 0; i < `VALU_XLEN / w; i++) begin
            r |= (rs1 & elem_mask(w)) << (i * w);
        end
        return rs1v ? r : vs1;
    endfunction

    function automatic void model(input valu_op_t op, input valu_ew_t sew,
                                  input logic [63:0] opa, input logic [63:0] vs2,
                                  input logic [63:0] old, input logic [7:0] mold,
                                  input logic [7:0] en,
                                  output logic [63:0] r_alu, output logic [7:0] r_mask);
        int          w;
        logic [63:0] m;
        logic [63:0] word;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] e;
        w = 8 << sew;
        m = elem_mask(w);
        case (op)
            AND:     word = vs2 & opa;
            OR:      word = vs2 | opa;
            XOR:     word = vs2 ^ opa;
            ANDN:    word = vs2 & ~opa;
            ORN:     word = vs2 | ~opa;
            NAND:    word = ~(vs2 & opa);
            NOR:     word = ~(vs2 | opa);
            XNOR:    word = ~(vs2 ^ opa);
            default: word = '0;
        endcase
        r_alu  = '0;
        r_mask = '0;
        for (int i = 0; i < `VALU_XLEN / w; i++) begin
            a = (opa >> (i * w)) & m;
            b = (vs2 >> (i * w)) & m;
            if (op >= AND && op <= XNOR) begin
                e = (word >> (i * w)) & m;
            end else begin
                e = alu_elem(op, w, a, b);
            end
            if (!en[i]) begin
                e = (old >> (i * w)) & m;
            end
            r_alu |= e << (i * w);
            r_mask[i] = en[i] ? cmp_elem(op, w, a, b) : mold[i];
        end
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // each element equal, off by one or random
    function automatic logic [63:0] near_copy(input valu_ew_t sew, input logic [63:0] a);
        int          w;
        logic [63:0] m;
        logic [63:0] e;
        logic [63:0] r;
        w = 8 << sew;
        m = elem_mask(w);
        r = '0;
        for (int i = 0; i < `VALU_XLEN / w; i++) begin
            e = (a >> (i * w)) & m;
            case ($urandom_range(0, 3))
                0:       e = e;
                1:       e = (e + 64'd1) & m;
                2:       e = (e - 64'd1) & m;
                default: e = rand_word() & m;
            endcase
            r |= e << (i * w);
        end
        return r;
    endfunction

    task automatic issue_op(input valu_op_t op, input valu_ew_t sew, input logic [63:0] vs1,
                            input logic rs1v, input logic [63:0] rs1, input logic [63:0] vs2,
                            input logic [63:0] old, input logic [7:0] mold,
                            input logic [7:0] en);
        logic [63:0] r_alu;
        logic [7:0]  r_mask;
        model(op, sew, operand_a(sew, rs1v, vs1, rs1), vs2, old, mold, en, r_alu, r_mask);
        exp_alu.push_back(r_alu);
        exp_mask.push_back(r_mask);
        exp_due.push_back(cyc + 2);                      // out two edges after issue
        i_valid       = 1'b1;
        i_op          = op;
        i_sew         = sew;
        i_vs1         = vs1;
        i_rs1_valid   = rs1v;
        i_rs1         = rs1;
        i_vs2         = vs2;
        i_wr_old      = old;
        i_wr_mask_old = mold;
        i_en_mask     = en;
        n_ops++;
        @(posedge i_clk);
        #1;
    endtask

    task automatic issue_random(input int lo, input int hi, input bit full_en);
        valu_op_t    op;
        valu_ew_t    sew;
        logic [7:0]  en;
        op  = valu_op_t'($urandom_range(lo, hi));
        sew = valu_ew_t'($urandom_range(0, 3));
        en  = full_en ? 8'hff : 8'($urandom);
        issue_op(op, sew, rand_word(), 1'($urandom_range(0, 1)), rand_word(), rand_word(),
                 rand_word(), 8'($urandom), en);
    endtask

    task automatic idle(input int n);
        i_valid = 1'b0;
        repeat (n) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
        test_ops0 = n_ops;
    endtask

    task automatic finish_test(input string name);
        idle(1);
        while (exp_due.size() != 0) begin
            idle(1);
        end
        idle(2);
        $display("test %s: %0d ops, %0d errors", name, n_ops - test_ops0, errors - test_err0);
    endtask

    // results land at the edge, sampled half a period later
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_valid) begin
                if (exp_due.size() == 0) begin
                    $display("result at %0t with no operation outstanding", $time);
                    errors++;
                end else begin
                    check_value("result cycle", 64'(exp_due[0]), 64'(cyc));
                    check_value("o_alu_res", exp_alu[0], o_alu_res);
                    check_value("o_mask_res", 64'(exp_mask[0]), 64'(o_mask_res));
                    void'(exp_due.pop_front());
                    void'(exp_alu.pop_front());
                    void'(exp_mask.pop_front());
                end
            end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
                $display("result due in cycle %0d never arrived", exp_due[0]);
                errors++;
                void'(exp_due.pop_front());
                void'(exp_alu.pop_front());
                void'(exp_mask.pop_front());
            end
        end
    end

    initial begin
        logic [63:0] a;
        logic [63:0] vs1;
        logic [63:0] rs1;
        logic        rs1v;
        int          run;
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_op = MV;
        i_sew = EW8;
        i_vs1 = '0;
        i_rs1_valid = 1'b0;
        i_rs1 = '0;
        i_vs2 = '0;
        i_wr_old = '0;
        i_wr_mask_old = '0;
        i_en_mask = '0;
        void'($urandom(32'h7f0aa798));
        repeat (RST_CYC) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        start_test();
        for (int i = 0; i < 4; i++) begin
            check_value("o_valid", 64'd0, 64'(o_valid));
            idle(1);
        end
        issue_op(MV, EW64, rand_word(), 1'b0, '0, '0, '0, '0, 8'hff);
        finish_test("reset_idle");

        start_test();
        for (int i = 0; i < N_ARITH; i++) issue_random(MV, SRA, 1'b1);
        finish_test("arith");

        start_test();
        for (int i = 0; i < N_BITWISE; i++) issue_random(AND, XNOR, 1'b1);
        finish_test("bitwise");

        // ----------------------------------------
        // compares with near-equal operands
        // ----------------------------------------
        start_test();
        for (int op = MSEQ; op <= MSGT; op++) begin
            for (int s = 0; s < 4; s++) begin
                for (int k = 0; k < N_CMP_REP; k++) begin
                    vs1  = rand_word();
                    rs1  = rand_word();
                    rs1v = 1'($urandom_range(0, 1));
                    a    = operand_a(valu_ew_t'(s), rs1v, vs1, rs1);
                    issue_op(valu_op_t'(op), valu_ew_t'(s), vs1, rs1v, rs1,
                             near_copy(valu_ew_t'(s), a), rand_word(), 8'($urandom),
                             8'($urandom));
                end
            end
        end
        finish_test("compare");

        start_test();
        for (int i = 0; i < N_ENABLE; i++) issue_random(MV, MSGT, 1'b0);
        finish_test("enable");

        start_test();
        while (n_ops - test_ops0 < N_B2B) begin
            run = 4 + int'($urandom_range(0, 20));
            for (int i = 0; i < run && n_ops - test_ops0 < N_B2B; i++) begin
                issue_random(MV, MSGT, 1'b0);
            end
            idle(int'($urandom_range(0, 3)));
        end
        finish_test("back_to_back");

        $display("tests 6, ops %0d, checks %0d, errors %0d", n_ops, n_checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/valu_pkg.sv
hdl/valu_operand_stage.sv
hdl/valu_arith_unit.sv
hdl/valu_compare_unit.sv
hdl/valu_result_merge.sv
hdl/valu_top.sv
tests/tb_valu_top.sv

//--- Makefile
# Verilator build and run of the vector ALU testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if sim.log holds the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_valu_top -Mdir obj_dir
	./obj_dir/Vtb_valu_top | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
